/* common/timer_cfg.svh */
/*
 * APB timer configuration
 * widths and sizes shared by the timer RTL and its testbench
 */

`ifndef TIMER_CFG_SVH
`define TIMER_CFG_SVH

// ****************************************
// bus widths
// ****************************************

// APB address width, only the low offset bits are decoded
`define TIMER_ADDR_W 12

// data bus and main counter width
`define TIMER_DATA_W 32

// ****************************************
// timer sizes
// ****************************************

`define TIMER_PRESC_W 8    // prescaler value and counter
`define TIMER_OFS_W   6    // register offset bits

`endif

/* common/timer_pkg.sv */
/*
 * APB timer types
 * register offsets, config register layout and channel traffic
 */

`include "timer_cfg.svh"

package timer_pkg;

   // register map, byte offsets
   typedef enum logic [`TIMER_OFS_W-1:0] {
      cfg_lo   = 6'h00,
      cfg_hi   = 6'h04,
      val_lo   = 6'h08,
      val_hi   = 6'h0C,
      cmp_lo   = 6'h10,
      cmp_hi   = 6'h14,
      start_lo = 6'h18,
      start_hi = 6'h1C,
      rst_lo   = 6'h20,
      rst_hi   = 6'h24
   } reg_ofs_e;

   // config register, msb first
   typedef struct packed {
      logic [`TIMER_DATA_W-`TIMER_PRESC_W-9:0] spare;  // reads back as written
      logic [`TIMER_PRESC_W-1:0]               presc_val;
      logic                                    ref_en;
      logic                                    presc_en;
      logic                                    one_shot;
      logic                                    cmp_clr;
      logic                                    event_en;
      logic                                    irq_en;
      logic                                    reset;   // self clearing
      logic                                    enable;
   } timer_cfg_t;

   // register block to channel
   typedef struct packed {
      logic                      enable;
      logic                      irq_en;
      logic                      cmp_clr;
      logic                      presc_en;
      logic                      ref_en;
      logic [`TIMER_PRESC_W-1:0] presc_val;
      logic [`TIMER_DATA_W-1:0]  cmp_val;
      logic                      clear;     // one cycle
      logic                      load;      // one cycle
      logic [`TIMER_DATA_W-1:0]  load_val;
   } chan_ctrl_t;

   // channel back to register block
   typedef struct packed {
      logic [`TIMER_DATA_W-1:0] count;
      logic                     target;
   } chan_stat_t;

endpackage

/* rtl/ref_clk_sync.sv */
/*
 * reference clock synchronizer
 * brings ref_clk_i into the HCLK domain and flags its rising edges
 */

module ref_clk_sync
(
   input  logic HCLK,
   input  logic HRESETn,
   input  logic ref_clk_i,
   output logic ref_edge_o
);

   logic [2:0] sync_q;   // [0] first stage, [2] last stage

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         sync_q <= '0;
      end
      else
      begin
         sync_q <= {sync_q[1:0], ref_clk_i};
      end
   end

   // rising edge seen between stage two and three
   assign ref_edge_o = sync_q[1] & ~sync_q[2];

endmodule

/* rtl/apb_timer_regs.sv */
/*
 * APB timer register block
 * decodes the zero-wait APB slave, holds config and compare registers
 * and turns writes, events and one-shot hits into channel controls
 */

`include "timer_cfg.svh"

module apb_timer_regs
   import timer_pkg::*;
(
   input  logic                     HCLK,
   input  logic                     HRESETn,
   input  logic                     psel_i,
   input  logic                     penable_i,
   input  logic                     pwrite_i,
   input  logic [`TIMER_ADDR_W-1:0] paddr_i,
   input  logic [`TIMER_DATA_W-1:0] pwdata_i,
   input  logic                     event_lo_i,
   input  logic                     event_hi_i,
   input  chan_stat_t               stat_lo_i,
   input  chan_stat_t               stat_hi_i,
   output logic [`TIMER_DATA_W-1:0] prdata_o,
   output chan_ctrl_t               ctrl_lo_o,
   output chan_ctrl_t               ctrl_hi_o,
   output logic                     busy_o
);

   reg_ofs_e                 ofs;
   logic                     wr_en;
   logic                     rd_en;
   logic [1:0]               wr_cfg;    // index 0 lo, 1 hi
   logic [1:0]               wr_val;
   logic [1:0]               wr_cmp;
   logic [1:0]               wr_start;
   logic [1:0]               wr_rst;
   logic [1:0]               event_in;
   chan_stat_t               stat  [2];
   chan_ctrl_t               ctrl  [2];
   timer_cfg_t               cfg_q [2];
   logic [`TIMER_DATA_W-1:0] cmp_q [2];

   assign ofs   = reg_ofs_e'(paddr_i[`TIMER_OFS_W-1:0]);
   assign wr_en = psel_i & penable_i & pwrite_i;
   assign rd_en = psel_i & penable_i & ~pwrite_i;

   assign event_in = {event_hi_i, event_lo_i};
   assign stat[0]  = stat_lo_i;
   assign stat[1]  = stat_hi_i;

   // ****************************************
   // write decode
   // ****************************************

   always_comb
   begin
      wr_cfg   = '0;
      wr_val   = '0;
      wr_cmp   = '0;
      wr_start = '0;
      wr_rst   = '0;
      if (wr_en)
      begin
         case (ofs)
            cfg_lo:   wr_cfg[0]   = 1'b1;
            cfg_hi:   wr_cfg[1]   = 1'b1;
            val_lo:   wr_val[0]   = 1'b1;
            val_hi:   wr_val[1]   = 1'b1;
            cmp_lo:   wr_cmp[0]   = 1'b1;
            cmp_hi:   wr_cmp[1]   = 1'b1;
            start_lo: wr_start[0] = 1'b1;
            start_hi: wr_start[1] = 1'b1;
            rst_lo:   wr_rst[0]   = 1'b1;
            rst_hi:   wr_rst[1]   = 1'b1;
            default:  ;   // unmapped, write ignored
         endcase
      end
   end

   // ****************************************
   // per channel registers
   // ****************************************

   for (genvar i = 0; i < 2; i++)
   begin : g_chan
      timer_cfg_t cfg_d;
      logic       os_stop;

      // one-shot target hit ends the run
      assign os_stop = cfg_q[i].one_shot & stat[i].target;

      always_comb
      begin
         cfg_d = cfg_q[i];
         if (wr_cfg[i])
            cfg_d = timer_cfg_t'(pwdata_i);
         else if (cfg_q[i].reset)
            cfg_d.reset = 1'b0;          // held for a single cycle

         // start and events win over one-shot and the bus
         if (wr_start[i] | (event_in[i] & cfg_q[i].event_en))
            cfg_d.enable = 1'b1;
         else if (os_stop)
            cfg_d.enable = 1'b0;
      end

      always_ff @(posedge HCLK, negedge HRESETn)
      begin
         if (!HRESETn)
         begin
            cfg_q[i] <= '0;
            cmp_q[i] <= '0;
         end
         else
         begin
            cfg_q[i] <= cfg_d;
            if (wr_cmp[i])
               cmp_q[i] <= pwdata_i;
         end
      end

      always_comb
      begin
         ctrl[i].enable    = cfg_q[i].enable & ~os_stop;  // no extra tick on the hit
         ctrl[i].irq_en    = cfg_q[i].irq_en;
         ctrl[i].cmp_clr   = cfg_q[i].cmp_clr;
         ctrl[i].presc_en  = cfg_q[i].presc_en;
         ctrl[i].ref_en    = cfg_q[i].ref_en;
         ctrl[i].presc_val = cfg_q[i].presc_val;
         ctrl[i].cmp_val   = cmp_q[i];
         ctrl[i].clear     = cfg_q[i].reset | wr_rst[i];
         ctrl[i].load      = wr_val[i];
         ctrl[i].load_val  = pwdata_i;
      end
   end

   assign ctrl_lo_o = ctrl[0];
   assign ctrl_hi_o = ctrl[1];

   assign busy_o = cfg_q[0].enable | cfg_q[1].enable;

   // ****************************************
   // read mux
   // ****************************************

   always_comb
   begin
      prdata_o = '0;
      if (rd_en)
      begin
         case (ofs)
            cfg_lo:  prdata_o = cfg_q[0];
            cfg_hi:  prdata_o = cfg_q[1];
            val_lo:  prdata_o = stat[0].count;   // live counter
            val_hi:  prdata_o = stat[1].count;
            cmp_lo:  prdata_o = cmp_q[0];
            cmp_hi:  prdata_o = cmp_q[1];
            default: prdata_o = '0;              // strobes and holes
         endcase
      end
   end

endmodule

/* timer_channel/timer_counter.sv */
/*
 * timer counter
 * up counter with load, clear and compare, used as prescaler and main counter
 */

module timer_counter
#(
   parameter int CNT_W = 32
)
(
   input  logic             HCLK,
   input  logic             HRESETn,
   input  logic             load_i,
   input  logic [CNT_W-1:0] load_val_i,
   input  logic             clear_i,
   input  logic             tick_i,
   input  logic [CNT_W-1:0] cmp_val_i,
   input  logic             wrap_i,      // back to 0 on a match
   output logic [CNT_W-1:0] count_o,
   output logic             target_o
);

   logic [CNT_W-1:0] count_q;
   logic             hit;

   // compare only counts on a real tick
   assign hit = tick_i & (count_q == cmp_val_i);

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         count_q  <= '0;
         target_o <= 1'b0;
      end
      else
      begin
         target_o <= 1'b0;   // pulse lasts one cycle
         if (load_i)
         begin
            count_q <= load_val_i;
         end
         else if (clear_i)
         begin
            count_q <= '0;
         end
         else if (tick_i)
         begin
            if (hit && wrap_i)
               count_q <= '0;
            else
               count_q <= count_q + 1'b1;
            target_o <= hit;
         end
      end
   end

   assign count_o = count_q;

endmodule

/* timer_channel/timer_channel.sv */
/*
 * timer channel
 * tick source select, optional prescaler, 32-bit main counter and irq gating
 */

`include "timer_cfg.svh"

module timer_channel
   import timer_pkg::*;
(
   input  logic       HCLK,
   input  logic       HRESETn,
   input  chan_ctrl_t ctrl_i,
   input  logic       ref_edge_i,
   output chan_stat_t stat_o,
   output logic       irq_o
);

   logic                     src_tick;
   logic                     presc_tick;
   logic                     presc_target;
   logic                     main_tick;
   logic [`TIMER_DATA_W-1:0] main_count;
   logic                     main_target;

   // ****************************************
   // tick selection
   // ****************************************

   // HCLK counts every cycle, ref clock only on its edge
   assign src_tick = ctrl_i.enable & (ctrl_i.ref_en ? ref_edge_i : 1'b1);

   assign presc_tick = ctrl_i.presc_en & src_tick;

   // prescaled path advances on the prescaler wrap pulse
   assign main_tick = ctrl_i.presc_en ? (presc_target & ctrl_i.enable) : src_tick;

   // ****************************************
   // counters
   // ****************************************

   timer_counter
   #(
      .CNT_W      (`TIMER_PRESC_W)
   )
   u_presc
   (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .load_i     (1'b0),
      .load_val_i ('0),
      .clear_i    (ctrl_i.clear),       // cleared with the main counter
      .tick_i     (presc_tick),
      .cmp_val_i  (ctrl_i.presc_val),
      .wrap_i     (1'b1),               // prescaler always wraps
      .count_o    (),
      .target_o   (presc_target)
   );

   timer_counter
   #(
      .CNT_W      (`TIMER_DATA_W)
   )
   u_main
   (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .load_i     (ctrl_i.load),
      .load_val_i (ctrl_i.load_val),
      .clear_i    (ctrl_i.clear),
      .tick_i     (main_tick),
      .cmp_val_i  (ctrl_i.cmp_val),
      .wrap_i     (ctrl_i.cmp_clr),
      .count_o    (main_count),
      .target_o   (main_target)
   );

   // ****************************************
   // status and irq
   // ****************************************

   assign stat_o.count  = main_count;
   assign stat_o.target = main_target;

   assign irq_o = main_target & ctrl_i.irq_en;   // one cycle pulse

endmodule

/* rtl/apb_timer_unit.sv */
/*
 * APB timer unit
 * two independent 32-bit timer channels behind a zero-wait APB slave
 */

`include "timer_cfg.svh"

module apb_timer_unit
   import timer_pkg::*;
(
   input  logic                     HCLK,
   input  logic                     HRESETn,
   input  logic [`TIMER_ADDR_W-1:0] PADDR,
   input  logic [`TIMER_DATA_W-1:0] PWDATA,
   input  logic                     PWRITE,
   input  logic                     PSEL,
   input  logic                     PENABLE,
   output logic [`TIMER_DATA_W-1:0] PRDATA,
   output logic                     PREADY,
   output logic                     PSLVERR,
   input  logic                     ref_clk_i,
   input  logic                     event_lo_i,
   input  logic                     event_hi_i,
   output logic                     irq_lo_o,
   output logic                     irq_hi_o,
   output logic                     busy_o
);

   chan_ctrl_t ctrl_lo;
   chan_ctrl_t ctrl_hi;
   chan_stat_t stat_lo;
   chan_stat_t stat_hi;
   logic       ref_edge;

   // every access completes in one cycle, no error response
   assign PREADY  = PSEL & PENABLE;
   assign PSLVERR = 1'b0;

   apb_timer_regs u_regs
   (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .psel_i     (PSEL),
      .penable_i  (PENABLE),
      .pwrite_i   (PWRITE),
      .paddr_i    (PADDR),
      .pwdata_i   (PWDATA),
      .event_lo_i (event_lo_i),
      .event_hi_i (event_hi_i),
      .stat_lo_i  (stat_lo),
      .stat_hi_i  (stat_hi),
      .prdata_o   (PRDATA),
      .ctrl_lo_o  (ctrl_lo),
      .ctrl_hi_o  (ctrl_hi),
      .busy_o     (busy_o)
   );

   ref_clk_sync u_ref_sync
   (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .ref_clk_i  (ref_clk_i),
      .ref_edge_o (ref_edge)
   );

   // shared ref edge, independent controls
   timer_channel u_chan_lo
   (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .ctrl_i     (ctrl_lo),
      .ref_edge_i (ref_edge),
      .stat_o     (stat_lo),
      .irq_o      (irq_lo_o)
   );

   timer_channel u_chan_hi
   (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .ctrl_i     (ctrl_hi),
      .ref_edge_i (ref_edge),
      .stat_o     (stat_hi),
      .irq_o      (irq_hi_o)
   );

endmodule

/* tests/tb_apb_timer.sv */
/*
 * APB timer testbench
 * drives the timer unit over APB and checks irq timing, readback and busy
 */

`include "timer_cfg.svh"

module tb_apb_timer
   import timer_pkg::*;
();

   localparam int APB_TMO = 8;
   localparam logic [31:0] CFG_EN  = 32'h01;   // config bits by the register layout
   localparam logic [31:0] CFG_RST = 32'h02;
   localparam logic [31:0] CFG_IRQ = 32'h04;
   localparam logic [31:0] CFG_EVT = 32'h08;
   localparam logic [31:0] CFG_CLR = 32'h10;
   localparam logic [31:0] CFG_ONE = 32'h20;
   localparam logic [31:0] CFG_PRE = 32'h40;
   localparam logic [31:0] CFG_REF = 32'h80;

   logic                     HCLK;
   logic                     HRESETn;
   logic [`TIMER_ADDR_W-1:0] PADDR;
   logic [`TIMER_DATA_W-1:0] PWDATA;
   logic                     PWRITE;
   logic                     PSEL;
   logic                     PENABLE;
   logic [`TIMER_DATA_W-1:0] PRDATA;
   logic                     PREADY;
   logic                     PSLVERR;
   logic                     ref_clk_i;
   logic                     event_lo_i;
   logic                     event_hi_i;
   logic                     irq_lo_o;
   logic                     irq_hi_o;
   logic                     busy_o;

   int          seed;
   int          errors;
   int          checks;
   int          tests;
   int          test_err;
   int unsigned cyc;
   int unsigned irq_lo_q[$];   // cycle stamps of irq pulses
   int unsigned irq_hi_q[$];
   logic        ref_run;
   int          ref_div;

   apb_timer_unit i_apb_timer_unit
   (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .PADDR      (PADDR),
      .PWDATA     (PWDATA),
      .PWRITE     (PWRITE),
      .PSEL       (PSEL),
      .PENABLE    (PENABLE),
      .PRDATA     (PRDATA),
      .PREADY     (PREADY),
      .PSLVERR    (PSLVERR),
      .ref_clk_i  (ref_clk_i),
      .event_lo_i (event_lo_i),
      .event_hi_i (event_hi_i),
      .irq_lo_o   (irq_lo_o),
      .irq_hi_o   (irq_hi_o),
      .busy_o     (busy_o)
   );

   always #4 HCLK = ~HCLK;

   // cycle stamps and irq capture
   always @(posedge HCLK)
   begin
      cyc <= cyc + 1;
      if (irq_lo_o)
         irq_lo_q.push_back(cyc);
      if (irq_hi_o)
         irq_hi_q.push_back(cyc);
   end

   // no error response on any access
   assert property (@(posedge HCLK) !(PSEL && PENABLE && PSLVERR))
   else
   begin
      $display("MISMATCH at %0t: PSLVERR high during an access", $time);
      errors++;
   end

   // ref clock toggles every 5 HCLK cycles
   always @(posedge HCLK)
   begin
      if (ref_run)
      begin
         ref_div <= (ref_div == 4) ? 0 : ref_div + 1;
         if (ref_div == 4)
            ref_clk_i <= ~ref_clk_i;
      end
   end

   // ****************************************
   // helpers
   // ****************************************

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      assert (got === exp)
      else
      begin
         $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic apb_xfer(input logic wr, input logic [`TIMER_ADDR_W-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
      int waited;
      @(posedge HCLK);
      PSEL    <= 1'b1;
      PENABLE <= 1'b0;
      PWRITE  <= wr;
      PADDR   <= addr;
      PWDATA  <= wdata;
      @(posedge HCLK);
      PENABLE <= 1'b1;
      waited = 0;
      do
      begin
         @(posedge HCLK);   // access phase ends here
         waited++;
      end
      while (!PREADY && waited < APB_TMO);
      if (!PREADY)
      begin
         $display("timeout: PREADY never came for offset 0x%03h", addr);
         errors++;
      end
      rdata   = PRDATA;
      PSEL    <= 1'b0;
      PENABLE <= 1'b0;
      PWRITE  <= 1'b0;
   endtask

   task automatic apb_write(input logic [`TIMER_ADDR_W-1:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      apb_xfer(1'b1, addr, data, unused);
   endtask

   task automatic read_expect(input logic [`TIMER_ADDR_W-1:0] addr, input logic [31:0] exp,
                              input string what);
      logic [31:0] d;
      apb_xfer(1'b0, addr, '0, d);
      check_eq(d, exp, what);
   endtask

   function automatic int irq_count(input bit hi);
      return hi ? irq_hi_q.size() : irq_lo_q.size();
   endfunction

   task automatic wait_irqs(input bit hi, input int n, input int tmo, output bit ok);
      int waited;
      waited = 0;
      while (irq_count(hi) < n && waited < tmo)
      begin
         @(posedge HCLK);
         waited++;
      end
      ok = (irq_count(hi) >= n);
      if (!ok)
      begin
         $display("timeout: %0d irq pulses on the %s channel never came", n, hi ? "hi" : "lo");
         errors++;
      end
   endtask

   task automatic check_intervals(input bit hi, input int n, input int exp, input string what);
      bit ok;
      wait_irqs(hi, n, exp * (n + 1) + 40, ok);
      for (int k = 1; ok && k < n; k++)
      begin
         if (hi)
            check_eq(irq_hi_q[k] - irq_hi_q[k-1], exp, what);
         else
            check_eq(irq_lo_q[k] - irq_lo_q[k-1], exp, what);
      end
   endtask

   task automatic wait_busy(input logic level, input string what);
      int waited;
      waited = 0;
      checks++;
      while (busy_o !== level && waited < 20)
      begin
         @(posedge HCLK);
         waited++;
      end
      if (busy_o !== level)
      begin
         $display("timeout: busy_o never went to %0d (%s)", level, what);
         errors++;
      end
   endtask

   task automatic pulse_event(input bit hi);
      @(posedge HCLK);
      if (hi)
         event_hi_i <= 1'b1;
      else
         event_lo_i <= 1'b1;
      @(posedge HCLK);
      event_lo_i <= 1'b0;
      event_hi_i <= 1'b0;
   endtask

   // turns both channels off and clears counters, prescalers and stale pulses
   task automatic stop_channels();
      apb_write(cfg_lo, '0);
      apb_write(cfg_hi, '0);
      ref_run <= 1'b0;
      repeat (4) @(posedge HCLK);
      apb_write(rst_lo, '0);
      apb_write(rst_hi, '0);
      irq_lo_q.delete();
      irq_hi_q.delete();
   endtask

   task automatic start_test();
      tests++;
      test_err = errors;
   endtask

   task automatic end_test(input string name);
      if (errors == test_err)
         $display("test %0d %s: pass", tests, name);
      else
         $display("test %0d %s: fail, %0d errors", tests, name, errors - test_err);
   endtask

   // ****************************************
   // stimulus
   // ****************************************

   initial
   begin
      logic [31:0] d;
      int          c_lo;
      int          c_hi;
      int          p;
      bit          ok;

      HCLK       = 1'b0;
      HRESETn    = 1'b0;
      PADDR      = '0;
      PWDATA     = '0;
      PWRITE     = 1'b0;
      PSEL       = 1'b0;
      PENABLE    = 1'b0;
      ref_clk_i  = 1'b0;
      event_lo_i = 1'b0;
      event_hi_i = 1'b0;
      seed       = 32'h86a8;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      cyc        = 0;
      ref_run    = 1'b0;
      ref_div    = 0;
      repeat (16) @(posedge HCLK);
      HRESETn <= 1'b1;
      @(posedge HCLK);

      start_test();
      check_eq(busy_o, 0, "busy_o after reset");
      check_eq({irq_hi_o, irq_lo_o}, 0, "irq outputs after reset");
      for (logic [`TIMER_ADDR_W-1:0] a = '0; a <= 'h28; a += 4)
         read_expect(a, '0, $sformatf("offset 0x%02h after reset", a));
      d = $random(seed);
      apb_write(cmp_lo, d);
      read_expect(cmp_lo, d, "cmp_lo readback");
      d = $random(seed);
      apb_write(cmp_hi, d);
      read_expect(cmp_hi, d, "cmp_hi readback");
      apb_write(val_lo, 32'hcafe_0011);
      read_expect(val_lo, 32'hcafe_0011, "val_lo after load");
      apb_write(val_hi, 32'h0bad_7700);
      read_expect(val_hi, 32'h0bad_7700, "val_hi after load");
      apb_write(cfg_hi, 32'h5a5a_0000);
      read_expect(cfg_hi, 32'h5a5a_0000, "cfg_hi spare bits");
      end_test("reset and readback");

      start_test();
      stop_channels();
      c_lo = 3 + ($unsigned($random(seed)) % 12);
      c_hi = c_lo + 1 + ($unsigned($random(seed)) % 6);   // differs from lo
      apb_write(cmp_lo, c_lo);
      apb_write(cmp_hi, c_hi);
      apb_write(cfg_lo, CFG_EN | CFG_IRQ | CFG_CLR);
      apb_write(cfg_hi, CFG_EN | CFG_IRQ | CFG_CLR);
      check_intervals(0, 4, c_lo + 1, "lo compare-clear interval");
      check_intervals(1, 4, c_hi + 1, "hi compare-clear interval");
      end_test("free-run compare-clear");

      start_test();
      stop_channels();
      c_lo = 2 + ($unsigned($random(seed)) % 6);
      p    = 1 + ($unsigned($random(seed)) % 4);
      apb_write(cmp_lo, c_lo);
      apb_write(cfg_lo, CFG_EN | CFG_IRQ | CFG_CLR | CFG_PRE | (p << 8));
      check_intervals(0, 4, (c_lo + 1) * (p + 1), "prescaled interval");
      end_test("prescaler");

      start_test();
      stop_channels();
      c_lo = 2 + ($unsigned($random(seed)) % 8);
      apb_write(cmp_lo, c_lo);
      apb_write(cfg_lo, CFG_EN | CFG_IRQ | CFG_ONE);
      wait_irqs(0, 1, c_lo + 40, ok);
      repeat (2 * (c_lo + 2)) @(posedge HCLK);   // window for a second pulse
      check_eq(irq_lo_q.size(), 1, "one-shot pulse count");
      read_expect(cfg_lo, CFG_IRQ | CFG_ONE, "cfg_lo after one-shot");
      check_eq(busy_o, 0, "busy_o after one-shot");
      read_expect(val_lo, c_lo + 1, "counter after one-shot");
      repeat (c_lo + 4) @(posedge HCLK);
      read_expect(val_lo, c_lo + 1, "counter holds after one-shot");
      end_test("one-shot");

      start_test();
      stop_channels();
      c_hi = 1 + ($unsigned($random(seed)) % 4);
      apb_write(cmp_hi, c_hi);
      ref_run <= 1'b1;
      apb_write(cfg_hi, CFG_EN | CFG_IRQ | CFG_CLR | CFG_REF);
      check_intervals(1, 3, 10 * (c_hi + 1), "ref clock interval");
      end_test("reference clock");

      start_test();
      stop_channels();
      apb_write(cfg_lo, CFG_EVT);
      check_eq(busy_o, 0, "busy_o before event");
      pulse_event(0);
      wait_busy(1'b1, "event start");
      read_expect(cfg_lo, CFG_EVT | CFG_EN, "cfg_lo after event start");
      apb_write(cfg_lo, '0);
      apb_xfer(1'b0, val_lo, '0, d);
      checks++;
      assert (d != 0)
      else
      begin
         $display("MISMATCH at %0t: lo counter did not run after event start", $time);
         errors++;
      end
      apb_write(rst_lo, '0);
      read_expect(val_lo, '0, "lo counter after rst write");
      apb_write(val_lo, 32'h0000_1234);
      apb_write(cfg_lo, CFG_RST);
      read_expect(cfg_lo, '0, "cfg_lo reset bit self-clears");
      read_expect(val_lo, '0, "lo counter after cfg reset bit");
      apb_write(start_hi, '0);
      wait_busy(1'b1, "start_hi write");
      read_expect(cfg_hi, CFG_EN, "cfg_hi after start write");
      apb_write(cfg_hi, '0);
      wait_busy(1'b0, "both channels stopped");
      pulse_event(0);
      pulse_event(1);
      repeat (4) @(posedge HCLK);
      check_eq(busy_o, 0, "busy_o after masked events");
      read_expect(cfg_lo, '0, "cfg_lo after masked event");
      read_expect(cfg_hi, '0, "cfg_hi after masked event");
      end_test("event start and strobes");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

/* project.f */
+incdir+common
common/timer_pkg.sv
rtl/ref_clk_sync.sv
rtl/apb_timer_regs.sv
timer_channel/timer_counter.sv
timer_channel/timer_channel.sv
rtl/apb_timer_unit.sv
tests/tb_apb_timer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the APB timer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_apb_timer -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_apb_timer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
   exit 1
fi
exit 0
